/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module caches_tb -f filelist.f -Mdir obj_dir -o caches_sim
	out="$$(./obj_dir/caches_sim)"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

/* filelist.f */
hw/cpu_types_pkg.sv
hw/datapath_cache_if.sv
hw/caches_if.sv
hw/dcache_array.sv
hw/dcache.sv
hw/caches.sv
testbench/caches_checker.sv
testbench/caches_tb.sv

/* hw/caches.sv */
// caches: data cache top level joining the controller and its storage array
`timescale 1ns/10ps

module caches import cpu_types_pkg::*; #(
  parameter int SET_BITS = SET_BITS_DEF
) (
  input  logic  CLK,
  input  logic  nRST,
  // Datapath side
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  output logic  dhit,
  output word_t dmem_load,
  output logic  flushed,
  // Memory side
  input  word_t ram_load,
  input  logic  ram_wait,
  output word_t ram_addr,
  output word_t ram_store,
  output logic  ram_ren,
  output logic  ram_wen
);

  datapath_cache_if dcif ();
  caches_if         cif ();
  cache_array_if #(.SET_BITS(SET_BITS)) arr_if ();

  assign dcif.dmem_ren   = dmem_ren;
  assign dcif.dmem_wen   = dmem_wen;
  assign dcif.dmem_addr  = dmem_addr;
  assign dcif.dmem_store = dmem_store;
  assign dcif.halt       = halt;
  assign dhit            = dcif.dhit;
  assign dmem_load       = dcif.dmem_load;
  assign flushed         = dcif.flushed;

  // Single cache, so the memory port goes straight out
  assign cif.dload = ram_load;
  assign cif.dwait = ram_wait;
  assign ram_addr  = cif.daddr;
  assign ram_store = cif.dstore;
  assign ram_ren   = cif.dren;
  assign ram_wen   = cif.dwen;

  dcache #(.SET_BITS(SET_BITS)) dcache_i (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif.cache),
    .cif  (cif.dcache),
    .arr  (arr_if.ctrl)
  );

  dcache_array #(.SET_BITS(SET_BITS)) array_i (
    .CLK  (CLK),
    .nRST (nRST),
    .arr  (arr_if.array)
  );

endmodule

/* hw/caches_if.sv */
// caches_if: single-word memory port between the data cache and main memory
`timescale 1ns/10ps

interface caches_if import cpu_types_pkg::*; ();

  logic  dren;
  logic  dwen;
  word_t daddr;
  word_t dstore;
  word_t dload;
  logic  dwait;   // Access completes in the first cycle this is low

  modport dcache (
    output dren, dwen, daddr, dstore,
    input  dload, dwait
  );

  modport mem (
    input  dren, dwen, daddr, dstore,
    output dload, dwait
  );

endinterface

/* hw/cpu_types_pkg.sv */
// cpu_types_pkg: word, address-field and controller state types for the data cache
package cpu_types_pkg;

  // One data word or byte address
  typedef logic [31:0] word_t;

  // Index bits at the default size of 8 sets
  parameter int SET_BITS_DEF = 3;

  // Tag at the default index width, 32 - 3 - 3
  typedef logic [25:0] tag_t;

  // Address as the cache sees it
  typedef struct packed {
    tag_t                    tag;
    logic [SET_BITS_DEF-1:0] idx;
    logic                    blkoff;  // Word within the block
    logic [1:0]              bytoff;
  } dcachef_t;

  // Controller states
  typedef enum logic [3:0] {
    IDLE,        // Serve hits, detect misses and halt
    WB0,         // Victim word 0 to memory
    WB1,         // Victim word 1 to memory
    FILL0,       // Read miss, fetch word 0
    FILL1,       // Read miss, fetch word 1
    ALLOC,       // Write miss, claim the victim entry
    FILL_OTHER,  // Write miss, fetch the word not being stored
    FLUSH_SCAN,  // Walk all entries looking for dirty ones
    FLUSH_WB0,
    FLUSH_WB1,
    STAT_WRITE,  // Store hits minus misses
    FLUSHED
  } cache_state_t;

  // Where the hit/miss statistic ends up after a flush
  parameter word_t STAT_ADDR = 32'h0000_3100;

endpackage

/* hw/datapath_cache_if.sv */
// datapath_cache_if: request and response signals between the datapath and the data cache
`timescale 1ns/10ps

interface datapath_cache_if import cpu_types_pkg::*; ();

  // Requests, held until dhit
  logic  dmem_ren;
  logic  dmem_wen;
  word_t dmem_addr;
  word_t dmem_store;
  logic  halt;

  // Responses
  logic  dhit;        // One-cycle pulse
  word_t dmem_load;
  logic  flushed;     // Level, stays up until reset

  modport cache (
    input  dmem_ren, dmem_wen, dmem_addr, dmem_store, halt,
    output dhit, dmem_load, flushed
  );

  modport dp (
    output dmem_ren, dmem_wen, dmem_addr, dmem_store, halt,
    input  dhit, dmem_load, flushed
  );

endinterface

/* hw/dcache.sv */
// dcache: data cache controller for hits, fills, write-backs, flush and hit/miss statistic
`timescale 1ns/10ps

module dcache import cpu_types_pkg::*; #(
  parameter int SET_BITS = SET_BITS_DEF
) (
  input logic             CLK,
  input logic             nRST,
  datapath_cache_if.cache dcif,
  caches_if.dcache        cif,
  cache_array_if.ctrl     arr
);
  localparam int TAG_BITS = 32 - SET_BITS - 3;

  cache_state_t        state, state_nxt;
  dcachef_t            query;
  logic [TAG_BITS-1:0] q_tag;
  logic [SET_BITS-1:0] q_idx;
  logic                hit;
  logic                victim;
  logic                flushing;
  logic                wb_way;
  logic                word_sel;
  word_t               wb_addr;
  logic [SET_BITS+1:0] flush_idx, flush_idx_nxt;  // {done, way, set}
  logic                flush_way;
  logic                flush_done;
  logic                retry, retry_nxt;          // Request already counted as a miss
  logic                hit_inc;
  logic                miss_inc;
  word_t               hit_cnt, miss_cnt;

  // Address fields; tag and index width follow SET_BITS
  assign query = dcachef_t'(dcif.dmem_addr);
  assign q_tag = dcif.dmem_addr[31:SET_BITS+3];
  assign q_idx = dcif.dmem_addr[SET_BITS+2:3];

  assign flush_way  = flush_idx[SET_BITS];
  assign flush_done = flush_idx[SET_BITS+1];
  assign flushing   = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1};

  assign hit    = arr.hit0 | arr.hit1;
  assign victim = arr.lru;

  // Second word of a write-back or fill
  assign word_sel = state inside {WB1, FLUSH_WB1, FILL1};
  assign wb_way   = flushing ? flush_way : victim;
  assign wb_addr  = {arr.rd_tag[wb_way], arr.idx, word_sel, 2'b00};

  assign arr.idx    = flushing ? flush_idx[SET_BITS-1:0] : q_idx;
  assign arr.wr_tag = q_tag;

  assign dcif.dmem_load = arr.rd_data[arr.hit_way][query.blkoff];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      flush_idx <= '0;
      retry     <= 1'b0;
      hit_cnt   <= '0;
      miss_cnt  <= '0;
    end
    else
    begin
      state     <= state_nxt;
      flush_idx <= flush_idx_nxt;
      retry     <= retry_nxt;
      if (!dcif.halt)  // Statistic frozen once the program is done
      begin
        if (hit_inc)
          hit_cnt <= hit_cnt + 1;
        if (miss_inc)
          miss_cnt <= miss_cnt + 1;
      end
    end
  end

  always_comb
  begin
    state_nxt     = state;
    flush_idx_nxt = flush_idx;
    retry_nxt     = retry;
    hit_inc       = 1'b0;
    miss_inc      = 1'b0;

    dcif.dhit    = 1'b0;
    dcif.flushed = 1'b0;
    cif.dren     = 1'b0;
    cif.dwen     = 1'b0;
    cif.daddr    = '0;
    cif.dstore   = '0;

    arr.wr_en    = 1'b0;
    arr.wr_way   = victim;       // Fills always go to the LRU way
    arr.wr_valid = 1'b1;
    arr.wr_dirty = 1'b0;
    arr.wr_data  = {2{cif.dload}};
    arr.wr_mask  = 2'b00;
    arr.lru_wr   = 1'b0;
    arr.lru_val  = ~arr.hit_way; // Other way becomes LRU

    case (state)
      IDLE:
      begin
        if (dcif.dmem_ren || dcif.dmem_wen)
        begin
          if (hit)
          begin
            dcif.dhit  = 1'b1;
            arr.lru_wr = 1'b1;
            hit_inc    = !retry;
            retry_nxt  = 1'b0;
            if (!dcif.dmem_ren)  // Store hit
            begin
              arr.wr_en    = 1'b1;
              arr.wr_way   = arr.hit_way;
              arr.wr_dirty = 1'b1;
              arr.wr_data  = {2{dcif.dmem_store}};
              arr.wr_mask  = query.blkoff ? 2'b10 : 2'b01;
            end
          end
          else
          begin
            miss_inc  = 1'b1;
            retry_nxt = 1'b1;
            if (arr.rd_dirty[victim])
              state_nxt = WB0;
            else if (dcif.dmem_ren)
              state_nxt = FILL0;
            else
              state_nxt = ALLOC;
          end
        end
        else if (dcif.halt)
          state_nxt = FLUSH_SCAN;
      end

      // Victim and flush write-backs share the same port behaviour
      WB0, WB1, FLUSH_WB0, FLUSH_WB1:
      begin
        cif.dwen   = 1'b1;
        cif.daddr  = wb_addr;
        cif.dstore = arr.rd_data[wb_way][word_sel];
        if (!cif.dwait)
        begin
          case (state)
            WB0:       state_nxt = WB1;
            WB1:       state_nxt = dcif.dmem_ren ? FILL0 : ALLOC;
            FLUSH_WB0: state_nxt = FLUSH_WB1;
            default:
            begin
              flush_idx_nxt = flush_idx + 1'b1;
              state_nxt     = FLUSH_SCAN;
            end
          endcase
        end
      end

      FILL0, FILL1:
      begin
        cif.dren  = 1'b1;
        cif.daddr = {q_tag, q_idx, word_sel, 2'b00};
        if (!cif.dwait)
        begin
          arr.wr_en    = 1'b1;
          arr.wr_valid = word_sel;  // Entry valid once both words are in
          arr.wr_mask  = word_sel ? 2'b10 : 2'b01;
          state_nxt    = word_sel ? IDLE : FILL1;
        end
      end

      ALLOC:
      begin
        arr.wr_en = 1'b1;  // New tag, data untouched
        state_nxt = FILL_OTHER;
      end

      FILL_OTHER:
      begin
        cif.dren  = 1'b1;
        cif.daddr = {q_tag, q_idx, ~query.blkoff, 2'b00};
        if (!cif.dwait)
        begin
          arr.wr_en   = 1'b1;
          arr.wr_mask = query.blkoff ? 2'b01 : 2'b10;
          state_nxt   = IDLE;  // Store lands on the hit in IDLE
        end
      end

      FLUSH_SCAN:
      begin
        if (flush_done)
          state_nxt = STAT_WRITE;
        else if (arr.rd_dirty[flush_way])
          state_nxt = FLUSH_WB0;
        else
          flush_idx_nxt = flush_idx + 1'b1;
      end

      STAT_WRITE:
      begin
        cif.dwen   = 1'b1;
        cif.daddr  = STAT_ADDR;
        cif.dstore = hit_cnt - miss_cnt;
        if (!cif.dwait)
          state_nxt = FLUSHED;
      end

      FLUSHED:
        dcif.flushed = 1'b1;

      default:
        state_nxt = IDLE;
    endcase
  end

endmodule

/* hw/dcache_array.sv */
// dcache_array: two-way tag and data storage with hit compare, LRU bits and masked update
`timescale 1ns/10ps

interface cache_array_if import cpu_types_pkg::*; #(
  parameter int SET_BITS = SET_BITS_DEF
) ();
  localparam int TAG_BITS = 32 - SET_BITS - 3;

  logic [SET_BITS-1:0]      idx;       // Selected set

  // Both ways of the selected set
  logic [1:0]               rd_valid;
  logic [1:0]               rd_dirty;
  logic [1:0][TAG_BITS-1:0] rd_tag;
  word_t [1:0][1:0]         rd_data;   // [way][word]
  logic                     hit0;
  logic                     hit1;
  logic                     hit_way;
  logic                     lru;       // Way to evict next

  // Update port
  logic                     wr_en;
  logic                     wr_way;
  logic [TAG_BITS-1:0]      wr_tag;    // Also the tag compared for hits
  logic                     wr_valid;
  logic                     wr_dirty;
  word_t [1:0]              wr_data;
  logic [1:0]               wr_mask;   // Which data words get written
  logic                     lru_wr;
  logic                     lru_val;

  modport ctrl (
    output idx, wr_en, wr_way, wr_tag, wr_valid, wr_dirty, wr_data, wr_mask,
    output lru_wr, lru_val,
    input  rd_valid, rd_dirty, rd_tag, rd_data, hit0, hit1, hit_way, lru
  );

  modport array (
    input  idx, wr_en, wr_way, wr_tag, wr_valid, wr_dirty, wr_data, wr_mask,
    input  lru_wr, lru_val,
    output rd_valid, rd_dirty, rd_tag, rd_data, hit0, hit1, hit_way, lru
  );
endinterface

module dcache_array import cpu_types_pkg::*; #(
  parameter int SET_BITS = SET_BITS_DEF
) (
  input logic         CLK,
  input logic         nRST,
  cache_array_if.array arr
);
  localparam int SETS     = 1 << SET_BITS;
  localparam int TAG_BITS = 32 - SET_BITS - 3;

  logic [TAG_BITS-1:0] tag_mem  [2][SETS];
  word_t               data_mem [2][SETS][2];
  logic [1:0][SETS-1:0] valid_q;
  logic [1:0][SETS-1:0] dirty_q;
  logic [SETS-1:0]      lru_q;

  // Combinational read of both ways
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      arr.rd_valid[w]   = valid_q[w][arr.idx];
      arr.rd_dirty[w]   = dirty_q[w][arr.idx];
      arr.rd_tag[w]     = tag_mem[w][arr.idx];
      arr.rd_data[w][0] = data_mem[w][arr.idx][0];
      arr.rd_data[w][1] = data_mem[w][arr.idx][1];
    end
  end

  assign arr.hit0    = arr.rd_valid[0] && (arr.rd_tag[0] == arr.wr_tag);
  assign arr.hit1    = arr.rd_valid[1] && (arr.rd_tag[1] == arr.wr_tag);
  assign arr.hit_way = arr.hit1;  // Way 0 unless way 1 hits
  assign arr.lru     = lru_q[arr.idx];

  // Entry state and LRU
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      if (arr.wr_en)
      begin
        valid_q[arr.wr_way][arr.idx] <= arr.wr_valid;
        dirty_q[arr.wr_way][arr.idx] <= arr.wr_dirty;
      end
      if (arr.lru_wr)
        lru_q[arr.idx] <= arr.lru_val;
    end
  end

  // Tags and data
  always_ff @(posedge CLK)
  begin
    if (arr.wr_en)
    begin
      tag_mem[arr.wr_way][arr.idx] <= arr.wr_tag;
      if (arr.wr_mask[0])
        data_mem[arr.wr_way][arr.idx][0] <= arr.wr_data[0];
      if (arr.wr_mask[1])
        data_mem[arr.wr_way][arr.idx][1] <= arr.wr_data[1];
    end
  end

endmodule

/* testbench/caches_checker.sv */
// caches_checker: watches the cache ports, keeps a shadow memory and counts mismatches
`timescale 1ns/10ps

module caches_checker import cpu_types_pkg::*; #(
  parameter int SET_BITS  = SET_BITS_DEF,
  parameter int MEM_WORDS = 4096
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  input  logic  dhit,
  input  word_t dmem_load,
  input  logic  flushed,
  input  logic  ram_ren,
  input  logic  ram_wen,
  input  word_t ram_addr,
  input  word_t mem_image [MEM_WORDS],  // Memory model contents
  input  logic  final_check,
  output int    errors
);
  localparam int STAT_IDX = int'(STAT_ADDR >> 2);

  word_t       shadow [MEM_WORDS];
  logic        pending;       // Request missed on its first cycle
  logic        last_ok;
  logic [31:3] last_blk;      // Block of the last completed request
  logic [11:0] widx;
  word_t       hits, misses;
  logic        flushed_seen;

  always @(posedge CLK)
  begin
    if (!nRST)
    begin
      foreach (shadow[i])
        shadow[i] = mem_image[i];
      pending      = 1'b0;
      last_ok      = 1'b0;
      last_blk     = '0;
      hits         = '0;
      misses       = '0;
      flushed_seen = 1'b0;
      errors       = 0;
    end
    else
    begin
      // Memory port is quiet unless a miss or the flush is in progress
      if ((ram_ren || ram_wen) && !pending && !halt)
      begin
        $display("ERROR: memory access at %h with no miss or flush underway", ram_addr);
        errors++;
      end
      else if (ram_ren && pending && ram_addr[31:3] != dmem_addr[31:3])
      begin
        $display("ERROR: fill read %h outside requested block %h", ram_addr, dmem_addr);
        errors++;
      end
      else if (ram_wen && pending && !halt &&
               (ram_addr[SET_BITS+2:3] != dmem_addr[SET_BITS+2:3] ||
                ram_addr[31:3] == dmem_addr[31:3]))
      begin
        $display("ERROR: write-back %h is not a victim block for %h", ram_addr, dmem_addr);
        errors++;
      end
      if ((ram_ren || ram_wen) && ram_addr[1:0] != 2'b00)
      begin
        $display("ERROR: memory address %h is not word aligned", ram_addr);
        errors++;
      end

      if (dmem_ren || dmem_wen)
      begin
        if (!pending)  // First cycle of this request
        begin
          if (last_ok && dmem_addr[31:3] == last_blk && !dhit)
          begin
            $display("FAIL hit_first_cycle addr %h expected dhit %b actual %b",
                     dmem_addr, 1'b1, dhit);
            errors++;
          end
          if (!halt)
          begin
            if (dhit)
              hits = hits + 1;
            else
              misses = misses + 1;
          end
        end
        if (dhit)
        begin
          widx = dmem_addr[13:2];
          if (dmem_ren)
          begin
            if (dmem_load !== shadow[widx])
            begin
              $display("FAIL read_data addr %h expected %h actual %h",
                       dmem_addr, shadow[widx], dmem_load);
              errors++;
            end
          end
          else
            shadow[widx] = dmem_store;
          last_blk = dmem_addr[31:3];
          last_ok  = 1'b1;
        end
      end
      pending = (dmem_ren || dmem_wen) && !dhit;

      if (flushed)
        flushed_seen = 1'b1;
      else if (flushed_seen)
      begin
        $display("ERROR: flushed dropped after it was raised");
        errors++;
      end

      if (final_check)
      begin
        if (!flushed)
        begin
          $display("ERROR: flushed is low at the end of the run");
          errors++;
        end
        foreach (shadow[i])
        begin
          if (i != STAT_IDX && mem_image[i] !== shadow[i])
          begin
            $display("FAIL flush_contents word %0d expected %h actual %h",
                     i, shadow[i], mem_image[i]);
            errors++;
          end
        end
        if (mem_image[STAT_IDX] !== hits - misses)
        begin
          $display("FAIL statistic expected %h actual %h", hits - misses, mem_image[STAT_IDX]);
          errors++;
        end
        $display("Counted %0d hits and %0d misses", hits, misses);
      end
    end
  end

endmodule

/* testbench/caches_tb.sv */
// caches_tb: clock, reset, random requests and a waiting memory model around the data cache
`timescale 1ns/10ps

module caches_tb import cpu_types_pkg::*; ();

  localparam int SET_BITS      = SET_BITS_DEF;
  localparam int MEM_WORDS     = 4096;
  localparam int REQUESTS      = 400;
  localparam int REQ_TIMEOUT   = 100;
  localparam int FLUSH_TIMEOUT = 2000;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  dmem_ren, dmem_wen, halt;
  word_t dmem_addr, dmem_store;
  logic  dhit, flushed;
  word_t dmem_load;
  word_t ram_load = '0;
  logic  ram_wait = 1'b1;
  word_t ram_addr, ram_store;
  logic  ram_ren, ram_wen;

  word_t      mem [MEM_WORDS];
  logic [1:0] wait_left = 2'd0;  // Extra wait cycles for the next access
  logic       final_check;
  int         chk_errors;
  int         timeouts;
  int         seed = 85862;
  word_t      prev_addr;

  always #4 CLK = ~CLK;

  caches #(.SET_BITS(SET_BITS)) caches_i (
    .CLK(CLK), .nRST(nRST),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .dmem_store(dmem_store), .halt(halt),
    .dhit(dhit), .dmem_load(dmem_load), .flushed(flushed),
    .ram_load(ram_load), .ram_wait(ram_wait), .ram_addr(ram_addr),
    .ram_store(ram_store), .ram_ren(ram_ren), .ram_wen(ram_wen)
  );

  caches_checker #(.SET_BITS(SET_BITS), .MEM_WORDS(MEM_WORDS)) checker_i (
    .CLK(CLK), .nRST(nRST),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .dmem_store(dmem_store), .halt(halt), .dhit(dhit), .dmem_load(dmem_load),
    .flushed(flushed), .ram_ren(ram_ren), .ram_wen(ram_wen), .ram_addr(ram_addr),
    .mem_image(mem), .final_check(final_check), .errors(chk_errors)
  );

  // Preload value that depends on the whole word address
  function automatic word_t fill_word(int a);
    return 32'h9E37_79B9 * word_t'(a) + 32'h1357_0000;
  endfunction

  // Memory model with one lookup cycle, then 0 to 3 extra wait cycles per access
  always @(posedge CLK)
  begin
    logic  in_rst, rd, wr;
    word_t a, d;
    in_rst = !nRST;
    rd     = ram_ren;
    wr     = ram_wen;
    a      = ram_addr;
    d      = ram_store;
    #1;
    if (in_rst)
    begin
      foreach (mem[i])
        mem[i] = fill_word(i);
      ram_wait  = 1'b1;
      wait_left = 2'd0;
    end
    else if (rd || wr)
    begin
      if (!ram_wait)  // Completed at this edge
      begin
        if (wr)
          mem[a[13:2]] = d;
        ram_wait  = 1'b1;
        wait_left = 2'($random(seed));
      end
      else if (wait_left != 2'd0)
        wait_left = wait_left - 2'd1;
      else
      begin
        ram_load = mem[a[13:2]];
        ram_wait = 1'b0;
      end
    end
  end

  // 4 tags x all sets x both words, or the previous block again
  task automatic pick_addr(input logic allow_repeat, output word_t a);
    word_t r, tag_v, idx_v;
    r = $random(seed);
    if (allow_repeat && r[4:3] == 2'b00)
      a = {prev_addr[31:3], r[2], 2'b00};
    else
    begin
      tag_v = (word_t'(r[6:5]) * 32'd3 + 32'd1) << (SET_BITS + 3);
      idx_v = (r >> 8) & word_t'((1 << SET_BITS) - 1);
      a     = tag_v | (idx_v << 3) | {29'd0, r[2], 2'b00};
    end
  endtask

  // Hold one request until dhit, then let the edge take it
  task automatic do_request(input logic wr, input word_t a, input word_t d);
    int t;
    dmem_ren   = !wr;
    dmem_wen   = wr;
    dmem_addr  = a;
    dmem_store = d;
    #1;  // dhit settles on the new request
    t = 0;
    while (!dhit && t < REQ_TIMEOUT)
    begin
      @(posedge CLK);
      #1;
      t++;
    end
    if (!dhit)
    begin
      $display("ERROR: no dhit within %0d cycles for address %h", REQ_TIMEOUT, a);
      timeouts++;
    end
    @(posedge CLK);
    #1;
  endtask

  initial
  begin
    int    n, t;
    word_t a, r;
    nRST        = 1'b0;
    dmem_ren    = 1'b0;
    dmem_wen    = 1'b0;
    dmem_addr   = '0;
    dmem_store  = '0;
    halt        = 1'b0;
    final_check = 1'b0;
    timeouts    = 0;
    prev_addr   = '0;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;

    for (n = 0; n < REQUESTS && timeouts == 0; n++)
    begin
      pick_addr(n > 0, a);
      r = $random(seed);
      do_request(r[2:0] < 3'd3, a, $random(seed));
      prev_addr = a;
      if (r[5:4] == 2'b00)  // Idle gap now and then
      begin
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        @(posedge CLK);
        #1;
      end
    end

    if (timeouts == 0)
    begin
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
      halt     = 1'b1;
      t = 0;
      while (!flushed && t < FLUSH_TIMEOUT)
      begin
        @(posedge CLK);
        #1;
        t++;
      end
      if (!flushed)
      begin
        $display("ERROR: flushed not raised within %0d cycles of halt", FLUSH_TIMEOUT);
        timeouts++;
      end
      else
      begin
        repeat (4) @(posedge CLK);
        #1;
        final_check = 1'b1;
        @(posedge CLK);
        #1;
        final_check = 1'b0;
      end
    end

    $display("Errors: %0d from checks, %0d timeouts", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
